//--- vlog.f
src/rw_pkg.sv
src/rw_addr_gen.sv
src/ar_fifo.sv
src/rw_read_stage.sv
src/rw_perf_counters.sv
src/rw_read_top.sv
testbench/tb_rw_read.sv

//--- run_sim.sh
#!/bin/sh
# build the read-stage testbench with Verilator, run it and look for the pass line.
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rw_read -f vlog.f -Mdir obj_dir \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_rw_read > sim.log 2>&1 \
   || echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
   || { echo "simulation failed"; exit 1; }

//--- testbench/tb_rw_read.sv
// read-stage testbench with directed tests, a memory responder and an undo-log model.
`timescale 1ns/100ps

module tb_rw_read;
   import rw_pkg::*;

   localparam int WAIT_LIMIT = 50;

   typedef struct packed {
      logic [31:0] addr;
      id_t         id;
   } ar_req_t;

   logic                      clk;
   logic                      rstn;
   logic                      task_in_valid;
   logic                      task_in_ready;
   task_t                     task_in;
   cq_slot_t                  cq_slot_in;
   thread_id_t                thread_id_in;
   logic                      gvt_slot_valid;
   cq_slot_t                  gvt_slot;
   logic                      arvalid;
   logic                      arready;
   logic [31:0]               araddr;
   id_t                       arid;
   logic                      rvalid;
   logic                      rready;
   id_t                       rid;
   logic [RDATA_WIDTH-1:0]    rdata;
   logic                      task_out_valid;
   logic                      task_out_ready;
   rw_write_t                 task_out;
   logic [FIFO_OCC_WIDTH-1:0] task_out_fifo_occ;
   reg_wr_t                   reg_wr;
   reg_rd_req_t               reg_rd_req;
   reg_rd_resp_t              reg_rd_resp;

   int          n_mismatch;
   int          n_other;
   logic [31:0] lcg_state;

   logic [RDATA_WIDTH-1:0] mem_lines [logic [25:0]];   // keyed by line address.
   ar_req_t                ar_q [$];

   // reads in flight per thread.
   task_t       issued_desc [N_THREADS];
   cq_slot_t    issued_slot [N_THREADS];
   logic [31:0] issued_addr [N_THREADS];

   logic [RW_WIDTH-1:0] undo_model [UNDO_LOG_DEPTH];   // last object out per slot.

   rw_read_top UUT (.*);

   always #50 clk = ~clk;

   // the memory records every request the DUT hands over.
   always @(negedge clk) begin
      #1;
      if (rstn && arvalid && arready) begin
         ar_q.push_back({araddr, arid});
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // a line is drawn from the generator the first time its address is touched.
   function automatic logic [RDATA_WIDTH-1:0] line_at(input logic [31:0] addr);
      logic [RDATA_WIDTH-1:0] line;
      int                     w;
      if (!mem_lines.exists(addr[31:6])) begin
         for (w = 0; w < RDATA_WIDTH / 32; w++) begin
            line[w*32 +: 32] = lcg_next() ^ (addr + w);
         end
         mem_lines[addr[31:6]] = line;
      end
      return mem_lines[addr[31:6]];
   endfunction

   function automatic task_t make_task(input task_type_e tt, input logic [31:0] obj,
                                       input logic nr);
      task_t t;
      t.ttype   = tt;
      t.ts      = lcg_next();
      t.object  = obj;
      t.no_read = nr;
      return t;
   endfunction

   task automatic verify_record(input rw_write_t got, input rw_write_t exp);
      if (got !== exp) begin
         $display("FAIL task_out got %h expected %h", got, exp);
         n_mismatch++;
      end
   endtask

   task automatic match_addr_req(input ar_req_t got, input logic [31:0] exp_addr,
                                 input id_t exp_id);
      if (got.addr !== exp_addr) begin
         $display("FAIL araddr got %h expected %h", got.addr, exp_addr);
         n_mismatch++;
      end
      if (got.id !== exp_id) begin
         $display("FAIL arid got %h expected %h", got.id, exp_id);
         n_mismatch++;
      end
   endtask

   task automatic check_reg_data(input logic [7:0] addr, input logic [31:0] got,
                                 input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL reg_rd_resp.rdata at %h got %h expected %h", addr, got, exp);
         n_mismatch++;
      end
   endtask

   task automatic write_register(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      reg_wr.wvalid = 1'b1;
      reg_wr.waddr  = addr;
      reg_wr.wdata  = data;
      @(negedge clk);
      reg_wr = '0;
   endtask

   task automatic fetch_register(input logic [7:0] addr, output logic [31:0] data,
                                 output bit ok);
      int i;
      ok   = 1'b0;
      data = '0;
      @(negedge clk);
      reg_rd_req.arvalid = 1'b1;
      reg_rd_req.araddr  = addr;
      @(negedge clk);
      reg_rd_req = '0;
      for (i = 0; i < WAIT_LIMIT && !ok; i++) begin
         #1;
         if (reg_rd_resp.rvalid) begin
            ok   = 1'b1;
            data = reg_rd_resp.rdata;
         end else begin
            @(negedge clk);
         end
      end
      if (!ok) begin
         $display("no register read response for address %h", addr);
         n_other++;
      end
   endtask

   // offers a task until it is taken or the limit runs out and returns at a falling edge.
   task automatic offer_task(input task_t t, input cq_slot_t slot, input thread_id_t thr,
                             input int limit, output bit accepted);
      int i;
      accepted = 1'b0;
      @(negedge clk);
      task_in_valid = 1'b1;
      task_in       = t;
      cq_slot_in    = slot;
      thread_id_in  = thr;
      for (i = 0; i < limit && !accepted; i++) begin
         #1;
         if (task_in_ready) accepted = 1'b1;
         else @(negedge clk);
      end
      if (accepted) begin
         @(negedge clk);   // the rising edge in between takes the task.
      end
      task_in_valid = 1'b0;
   endtask

   task automatic expect_bypass(input task_t t, input cq_slot_t slot, input thread_id_t thr);
      rw_write_t exp;
      bit        seen;
      int        i;
      exp.task_desc = t;
      exp.cq_slot   = slot;
      exp.thread    = thr;
      exp.object    = (t.ttype == TASK_UNDO_LOG_RESTORE) ? undo_model[slot] : '0;
      seen = 1'b0;
      for (i = 0; i < WAIT_LIMIT && !seen; i++) begin
         #1;
         if (task_out_valid) begin
            seen = 1'b1;
            verify_record(task_out, exp);
            undo_model[slot] = exp.object;   // ready is high so it transfers.
         end else begin
            @(negedge clk);
         end
      end
      if (!seen) begin
         $display("no bypass record appeared for slot %0d", slot);
         n_other++;
      end
   endtask

   task automatic run_bypass(input task_type_e tt, input logic [31:0] obj, input cq_slot_t slot,
                             input thread_id_t thr);
      task_t t;
      bit    acc;
      t = make_task(tt, obj, 1'b1);
      offer_task(t, slot, thr, WAIT_LIMIT, acc);
      if (acc) begin
         expect_bypass(t, slot, thr);
      end else begin
         $display("bypass task for slot %0d was never accepted", slot);
         n_other++;
      end
   endtask

   task automatic wait_requests(input int n);
      int i;
      for (i = 0; i < WAIT_LIMIT && ar_q.size() < n; i++) begin
         @(negedge clk);
      end
      if (ar_q.size() < n) begin
         $display("only %0d of %0d address requests arrived", ar_q.size(), n);
         n_other++;
      end
   endtask

   // the memory answers the newest request first.
   task automatic answer_reads();
      ar_req_t                req;
      rw_write_t              exp;
      logic [RDATA_WIDTH-1:0] line;
      bit                     seen;
      int                     i;
      while (ar_q.size() > 0) begin
         req = ar_q.pop_back();
         @(negedge clk);
         rvalid = 1'b1;
         rid    = req.id;
         rdata  = line_at(req.addr);
         line   = line_at(issued_addr[req.id]);
         exp.task_desc = issued_desc[req.id];
         exp.cq_slot   = issued_slot[req.id];
         exp.thread    = req.id;
         exp.object    = line[issued_desc[req.id].object[3:0] * 32 +: 32];
         seen = 1'b0;
         for (i = 0; i < WAIT_LIMIT && !seen; i++) begin
            #1;
            if (rready) begin
               seen = 1'b1;
               verify_record(task_out, exp);
               undo_model[exp.cq_slot] = exp.object;
            end else begin
               @(negedge clk);
            end
         end
         if (!seen) begin
            $display("read data for thread %0d was never taken", req.id);
            n_other++;
         end
      end
      @(negedge clk);
      rvalid = 1'b0;
   endtask

   task automatic apply_reset();
      rstn = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      #1;
      if (arvalid || task_out_valid || rready || reg_rd_resp.rvalid) begin
         $display("a handshake output is high right after reset");
         n_other++;
      end
   endtask

   task automatic form_addresses();
      task_t      t;
      thread_id_t thr;
      bit         acc;
      int         k;
      write_register(REG_RW_BASE_ADDR, 32'h100);
      for (k = 0; k < 4; k++) begin
         thr = thread_id_t'(k * 3 + 2);
         t   = make_task(TASK_NORMAL, 32'(3 + k * 41), 1'b0);
         offer_task(t, cq_slot_t'(11 * (k + 1)), thr, WAIT_LIMIT, acc);
         if (!acc) begin
            $display("read task for thread %0d was never accepted", thr);
            n_other++;
         end
         issued_desc[thr] = t;
         issued_slot[thr] = cq_slot_t'(11 * (k + 1));
         issued_addr[thr] = 32'h400 + t.object * 4;
      end
      wait_requests(4);
      for (k = 0; k < 4 && k < ar_q.size(); k++) begin
         thr = thread_id_t'(k * 3 + 2);
         match_addr_req(ar_q[k], issued_addr[thr], thr);
      end
   endtask

   task automatic exhaust_budget();
      task_t t;
      bit    acc;
      int    k;
      write_register(REG_N_DEQUEUES, 32'd3);
      for (k = 0; k < 5; k++) begin
         t = make_task(TASK_NORMAL, 32'(k), 1'b1);
         offer_task(t, cq_slot_t'(50 + k), thread_id_t'(k), WAIT_LIMIT, acc);
         if (acc) expect_bypass(t, cq_slot_t'(50 + k), thread_id_t'(k));
         if (acc != (k < 3)) begin
            $display("task %0d under a budget of 3 was wrongly %s", k,
                     acc ? "accepted" : "refused");
            n_other++;
         end
      end
      write_register(REG_N_DEQUEUES, 32'hffff_ffff);
   endtask

   task automatic gvt_override();
      task_t t;
      bit    acc;
      write_register(REG_FIFO_THRESH, 32'd4);
      task_out_fifo_occ = 8'd6;
      t = make_task(TASK_NORMAL, 32'h9, 1'b1);
      offer_task(t, 6'd9, 3'd3, 20, acc);
      if (acc) begin
         $display("task was accepted with occupancy above the threshold");
         n_other++;
         expect_bypass(t, 6'd9, 3'd3);
         @(negedge clk);
      end
      gvt_slot_valid = 1'b1;   // slot 9 is now the oldest.
      gvt_slot       = 6'd9;
      offer_task(t, 6'd9, 3'd3, 20, acc);
      if (acc) begin
         expect_bypass(t, 6'd9, 3'd3);
      end else begin
         $display("task matching the gvt slot was never accepted");
         n_other++;
      end
      @(negedge clk);
      gvt_slot_valid    = 1'b0;
      task_out_fifo_occ = '0;
      write_register(REG_FIFO_THRESH, 32'hff);
   endtask

   task automatic count_processed();
      logic [31:0] data;
      bit          ok;
      write_register(REG_START, 32'd1);
      run_bypass(TASK_NORMAL, 32'h7, 6'd60, 3'd0);
      run_bypass(TASK_UNDO_LOG_RESTORE, 32'h0, 6'd60, 3'd1);
      run_bypass(TASK_UNDO_LOG_RESTORE, 32'h0, 6'd33, 3'd2);
      fetch_register(REG_CYC_PROCESSED, data, ok);
      if (ok) check_reg_data(REG_CYC_PROCESSED, data, 32'd3);   // three tasks since start.
      fetch_register(REG_DEBUG_WORD, data, ok);
      if (ok) check_reg_data(REG_DEBUG_WORD, data, 32'h0000_0041);   // only both readies high.
   endtask

   initial begin
      clk               = 1'b0;
      rstn              = 1'b0;
      task_in_valid     = 1'b0;
      task_in           = '0;
      cq_slot_in        = '0;
      thread_id_in      = '0;
      gvt_slot_valid    = 1'b0;
      gvt_slot          = '0;
      arready           = 1'b1;
      rvalid            = 1'b0;
      rid               = '0;
      rdata             = '0;
      task_out_ready    = 1'b1;
      task_out_fifo_occ = '0;
      reg_wr            = '0;
      reg_rd_req        = '0;
      n_mismatch        = 0;
      n_other           = 0;
      lcg_state         = 32'd91;
      apply_reset();
      form_addresses();
      if (ar_q.size() != 4) begin
         $display("expected 4 queued reads before answering, found %0d", ar_q.size());
         n_other++;
      end
      answer_reads();
      run_bypass(TASK_NORMAL, 32'h55, 6'd22, 3'd1);
      run_bypass(TASK_UNDO_LOG_RESTORE, 32'h0, 6'd11, 3'd2);
      run_bypass(TASK_UNDO_LOG_RESTORE, 32'h0, 6'd22, 3'd4);
      run_bypass(TASK_UNDO_LOG_RESTORE, 32'h0, 6'd44, 3'd6);
      exhaust_budget();
      gvt_override();
      count_processed();
      repeat (2) @(negedge clk);
      $display("errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
      if (n_mismatch + n_other == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- src/rw_read_top.sv
// read-stage top: dispatch, address generation, request FIFO and counters.
`timescale 1ns/100ps

module rw_read_top (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              task_in_valid,
   output logic                              task_in_ready,
   input  rw_pkg::task_t                     task_in,
   input  rw_pkg::cq_slot_t                  cq_slot_in,
   input  rw_pkg::thread_id_t                thread_id_in,
   input  logic                              gvt_slot_valid,
   input  rw_pkg::cq_slot_t                  gvt_slot,
   output logic                              arvalid,
   input  logic                              arready,
   output logic [31:0]                       araddr,
   output rw_pkg::id_t                       arid,
   input  logic                              rvalid,
   output logic                              rready,
   input  rw_pkg::id_t                       rid,
   input  logic [rw_pkg::RDATA_WIDTH-1:0]    rdata,
   output logic                              task_out_valid,
   input  logic                              task_out_ready,
   output rw_pkg::rw_write_t                 task_out,
   input  logic [rw_pkg::FIFO_OCC_WIDTH-1:0] task_out_fifo_occ,
   input  rw_pkg::reg_wr_t                   reg_wr,
   input  rw_pkg::reg_rd_req_t               reg_rd_req,
   output rw_pkg::reg_rd_resp_t              reg_rd_resp
);
   import rw_pkg::*;

   logic [31:0] gen_araddr;
   logic        ar_push;
   id_t         ar_id;
   logic        ar_full;
   logic        ar_empty;
   logic        fifo_stall;
   logic        mem_stall;

   assign arvalid   = !ar_empty;
   assign mem_stall = arvalid && !arready;

   rw_addr_gen u_addr_gen (
      .clk     (clk),
      .rstn    (rstn),
      .task_in (task_in),
      .reg_wr  (reg_wr),
      .araddr  (gen_araddr)
   );

   rw_read_stage u_read_stage (
      .clk               (clk),
      .rstn              (rstn),
      .task_in_valid     (task_in_valid),
      .task_in_ready     (task_in_ready),
      .task_in           (task_in),
      .cq_slot_in        (cq_slot_in),
      .thread_id_in      (thread_id_in),
      .gvt_slot_valid    (gvt_slot_valid),
      .gvt_slot          (gvt_slot),
      .araddr_in         (gen_araddr),
      .ar_full           (ar_full),
      .ar_push           (ar_push),
      .ar_id             (ar_id),
      .rvalid            (rvalid),
      .rready            (rready),
      .rid               (rid),
      .rdata             (rdata),
      .task_out_valid    (task_out_valid),
      .task_out_ready    (task_out_ready),
      .task_out          (task_out),
      .task_out_fifo_occ (task_out_fifo_occ),
      .reg_wr            (reg_wr),
      .fifo_stall        (fifo_stall)
   );

   // entries carry the address with the thread as read tag.
   ar_fifo u_ar_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (ar_push),
      .wr_data ({gen_araddr, ar_id}),
      .rd_en   (arvalid && arready),
      .rd_data ({araddr, arid}),
      .full    (ar_full),
      .empty   (ar_empty)
   );

   rw_perf_counters u_perf_counters (
      .clk               (clk),
      .rstn              (rstn),
      .task_in_valid     (task_in_valid),
      .task_in_ready     (task_in_ready),
      .fifo_stall        (fifo_stall),
      .mem_stall         (mem_stall),
      .task_out_fifo_occ (task_out_fifo_occ),
      .handshake_bits    ({arvalid, arready, rvalid, rready,
                           task_in_valid, task_in_ready, task_out_valid, task_out_ready}),
      .reg_wr            (reg_wr),
      .reg_rd_req        (reg_rd_req),
      .reg_rd_resp       (reg_rd_resp)
   );

endmodule

//--- src/rw_perf_counters.sv
// read-stage performance counters: stall classification and register read responses.
`timescale 1ns/100ps

module rw_perf_counters (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              task_in_valid,
   input  logic                              task_in_ready,
   input  logic                              fifo_stall,
   input  logic                              mem_stall,
   input  logic [rw_pkg::FIFO_OCC_WIDTH-1:0] task_out_fifo_occ,
   input  logic [7:0]                        handshake_bits,
   input  rw_pkg::reg_wr_t                   reg_wr,
   input  rw_pkg::reg_rd_req_t               reg_rd_req,
   output rw_pkg::reg_rd_resp_t              reg_rd_resp
);
   import rw_pkg::*;

   logic        started;
   cyc_class_e  cyc_class;
   logic [31:0] cyc_cnt [N_CYC_CLASSES];
   logic [31:0] rd_word;
   logic        resp_valid;
   logic [31:0] resp_data;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         started <= 1'b0;
      end else if (reg_wr.wvalid && reg_wr.waddr == REG_START) begin
         started <= reg_wr.wdata[0];
      end
   end

   // priority order decides the class of each cycle.
   always_comb begin
      if (!task_in_valid) cyc_class = CLS_NO_TASK;
      else if (task_in_ready) cyc_class = CLS_PROCESSED;
      else if (fifo_stall) cyc_class = CLS_STALL_FIFO;
      else if (mem_stall) cyc_class = CLS_STALL_MEM;
      else cyc_class = CLS_UNASSIGNED;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < N_CYC_CLASSES; i++) begin
            cyc_cnt[i] <= '0;
         end
      end else if (started) begin
         cyc_cnt[cyc_class] <= cyc_cnt[cyc_class] + 1'b1;
      end
   end

   always_comb begin
      case (reg_rd_req.araddr)
         REG_CYC_NO_TASK:    rd_word = cyc_cnt[CLS_NO_TASK];
         REG_CYC_PROCESSED:  rd_word = cyc_cnt[CLS_PROCESSED];
         REG_CYC_STALL_FIFO: rd_word = cyc_cnt[CLS_STALL_FIFO];
         REG_CYC_STALL_MEM:  rd_word = cyc_cnt[CLS_STALL_MEM];
         REG_CYC_UNASSIGNED: rd_word = cyc_cnt[CLS_UNASSIGNED];
         REG_FIFO_THRESH:    rd_word = {{(32-FIFO_OCC_WIDTH){1'b0}}, task_out_fifo_occ};
         REG_DEBUG_WORD:     rd_word = {24'b0, handshake_bits};   // live handshake snapshot.
         default:            rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= reg_rd_req.arvalid;   // single-cycle pulse.
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd_req.arvalid) begin
         resp_data <= rd_word;
      end
   end

   assign reg_rd_resp.rvalid = resp_valid;
   assign reg_rd_resp.rdata  = resp_data;

endmodule

//--- src/rw_read_stage.sv
// read stage: task dispatch, per-thread descriptors, undo log and output selection.
`timescale 1ns/100ps

module rw_read_stage (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              task_in_valid,
   output logic                              task_in_ready,
   input  rw_pkg::task_t                     task_in,
   input  rw_pkg::cq_slot_t                  cq_slot_in,
   input  rw_pkg::thread_id_t                thread_id_in,
   input  logic                              gvt_slot_valid,
   input  rw_pkg::cq_slot_t                  gvt_slot,
   input  logic [31:0]                       araddr_in,
   input  logic                              ar_full,
   output logic                              ar_push,
   output rw_pkg::id_t                       ar_id,
   input  logic                              rvalid,
   output logic                              rready,
   input  rw_pkg::id_t                       rid,
   input  logic [rw_pkg::RDATA_WIDTH-1:0]    rdata,
   output logic                              task_out_valid,
   input  logic                              task_out_ready,
   output rw_pkg::rw_write_t                 task_out,
   input  logic [rw_pkg::FIFO_OCC_WIDTH-1:0] task_out_fifo_occ,
   input  rw_pkg::reg_wr_t                   reg_wr,
   output logic                              fifo_stall
);
   import rw_pkg::*;

   logic [31:0]               dequeues_remaining;
   logic [FIFO_OCC_WIDTH-1:0] fifo_thresh;
   logic                      occ_ok;
   logic                      byp_free;
   logic                      can_dequeue;
   logic                      out_xfer;

   // descriptors of tasks waiting on memory, one per thread.
   task_t    task_desc [N_THREADS];
   cq_slot_t task_slot [N_THREADS];
   task_t    rd_desc;

   logic [RW_WIDTH-1:0] undo_log [UNDO_LOG_DEPTH];
   logic [RW_WIDTH-1:0] undo_rd_word;

   // one-entry holding register for tasks that skip memory.
   logic       byp_valid;
   task_t      byp_task;
   cq_slot_t   byp_slot;
   thread_id_t byp_thread;

   assign fifo_stall = (task_out_fifo_occ >= fifo_thresh);

   // the oldest task may pass the threshold.
   assign occ_ok   = !fifo_stall || (gvt_slot_valid && gvt_slot == cq_slot_in);
   assign byp_free = !byp_valid || task_out_ready;

   always_comb begin
      can_dequeue = (dequeues_remaining != '0) && occ_ok;
      if (task_in.no_read) begin
         can_dequeue = can_dequeue && byp_free;
      end else begin
         can_dequeue = can_dequeue && !ar_full;
      end
   end

   assign task_in_ready = task_in_valid && can_dequeue;
   assign ar_push       = task_in_ready && !task_in.no_read;
   assign ar_id         = thread_id_in;

   // threshold and budget, a register write wins over the decrement.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         fifo_thresh        <= '1;
         dequeues_remaining <= '1;
      end else if (reg_wr.wvalid) begin
         case (reg_wr.waddr)
            REG_FIFO_THRESH: fifo_thresh <= reg_wr.wdata[FIFO_OCC_WIDTH-1:0];
            REG_N_DEQUEUES:  dequeues_remaining <= reg_wr.wdata;
            default: ;
         endcase
      end else if (task_in_ready) begin
         dequeues_remaining <= dequeues_remaining - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_push) begin
         task_desc[thread_id_in] <= task_in;
         task_slot[thread_id_in] <= cq_slot_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         byp_valid <= 1'b0;
      end else if (task_in_ready && task_in.no_read) begin
         byp_valid <= 1'b1;
      end else if (byp_valid && task_out_ready) begin
         byp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (task_in_ready && task_in.no_read) begin
         byp_task   <= task_in;
         byp_slot   <= cq_slot_in;
         byp_thread <= thread_id_in;
      end
   end

   assign out_xfer = task_out_valid && task_out_ready;

   // the read word is frozen while a bypass record waits, so a restore keeps its object.
   always_ff @(posedge clk) begin
      if (out_xfer) begin
         undo_log[task_out.cq_slot] <= task_out.object;
      end
      if (byp_free) begin
         if (out_xfer && task_out.cq_slot == cq_slot_in) begin
            undo_rd_word <= task_out.object;   // same-edge write forwards.
         end else begin
            undo_rd_word <= undo_log[cq_slot_in];
         end
      end
   end

   always_comb begin
      rd_desc        = task_desc[rid];
      task_out_valid = 1'b0;
      rready         = 1'b0;
      if (byp_valid) begin
         task_out.task_desc = byp_task;
         task_out.cq_slot   = byp_slot;
         task_out.thread    = byp_thread;
         task_out.object    = (byp_task.ttype == TASK_UNDO_LOG_RESTORE) ? undo_rd_word : '0;
         task_out_valid     = 1'b1;
      end else begin
         task_out.task_desc = rd_desc;
         task_out.cq_slot   = task_slot[rid];
         task_out.thread    = rid;
         task_out.object    = rdata[rd_desc.object[LOG_WORDS_PER_BEAT-1:0] * RW_WIDTH +: RW_WIDTH];
         task_out_valid     = rvalid;
         rready             = rvalid && task_out_ready;
      end
   end

   // an empty budget stays empty until software refills it.
   a_budget_hold: assert property (@(posedge clk) disable iff (!rstn)
      (dequeues_remaining == '0 && !reg_wr.wvalid) |=> dequeues_remaining == '0);

   a_rready_rvalid: assert property (@(posedge clk) disable iff (!rstn)
      rready |-> (rvalid && !byp_valid));

   // address generator output must stay word aligned on every push.
   a_araddr_aligned: assert property (@(posedge clk) disable iff (!rstn)
      ar_push |-> araddr_in[LOG_RW_WIDTH-1:0] == '0);

endmodule

//--- src/ar_fifo.sv
// address request FIFO: eight-entry circular buffer for outgoing read requests.
`timescale 1ns/100ps

module ar_fifo (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              wr_en,
   input  logic [rw_pkg::AR_ENTRY_WIDTH-1:0] wr_data,
   input  logic                              rd_en,
   output logic [rw_pkg::AR_ENTRY_WIDTH-1:0] rd_data,
   output logic                              full,
   output logic                              empty
);
   import rw_pkg::*;

   logic [AR_ENTRY_WIDTH-1:0] mem [AR_FIFO_DEPTH];

   // one extra pointer bit tells full from empty.
   logic [AR_FIFO_LOG_DEPTH:0] wr_ptr;
   logic [AR_FIFO_LOG_DEPTH:0] rd_ptr;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AR_FIFO_LOG_DEPTH] != rd_ptr[AR_FIFO_LOG_DEPTH]) &&
                  (wr_ptr[AR_FIFO_LOG_DEPTH-1:0] == rd_ptr[AR_FIFO_LOG_DEPTH-1:0]);

   assign rd_data = mem[rd_ptr[AR_FIFO_LOG_DEPTH-1:0]];   // head shows without a pop.

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[AR_FIFO_LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // the dispatcher checks full and the address port checks empty.
   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty);

endmodule

//--- src/rw_addr_gen.sv
// object address generator: base register plus scaled object index.
`timescale 1ns/100ps

module rw_addr_gen (
   input  logic            clk,
   input  logic            rstn,
   input  rw_pkg::task_t   task_in,
   input  rw_pkg::reg_wr_t reg_wr,
   output logic [31:0]     araddr
);
   import rw_pkg::*;

   logic [31:0] base_addr;

   // software writes a word index, the register holds a byte address.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_addr <= '0;
      end else if (reg_wr.wvalid && reg_wr.waddr == REG_RW_BASE_ADDR) begin
         base_addr <= {reg_wr.wdata[29:0], 2'b00};
      end
   end

   assign araddr = base_addr + (task_in.object << LOG_RW_WIDTH);

endmodule

//--- src/rw_pkg.sv
// rw read-stage package: task, slot, register-bus and output types plus sizing constants.
package rw_pkg;

   // sizing.
   localparam int N_THREADS          = 8;
   localparam int LOG_CQ_SLICE_SIZE  = 6;
   localparam int UNDO_LOG_DEPTH     = 1 << LOG_CQ_SLICE_SIZE;
   localparam int LOG_RW_WIDTH       = 2;   // bytes per object, as log2.
   localparam int RW_WIDTH           = 8 << LOG_RW_WIDTH;
   localparam int RDATA_WIDTH        = 512;
   localparam int LOG_WORDS_PER_BEAT = 4;   // 16 objects per read beat.
   localparam int FIFO_OCC_WIDTH     = 8;
   localparam int THREAD_ID_WIDTH    = 3;

   // address request FIFO, 32-bit address followed by the read tag.
   localparam int AR_FIFO_LOG_DEPTH  = 3;
   localparam int AR_FIFO_DEPTH      = 1 << AR_FIFO_LOG_DEPTH;
   localparam int AR_ENTRY_WIDTH     = 32 + THREAD_ID_WIDTH;

   // register map.
   localparam logic [7:0] REG_RW_BASE_ADDR   = 8'h10;
   localparam logic [7:0] REG_FIFO_THRESH    = 8'h14;
   localparam logic [7:0] REG_N_DEQUEUES     = 8'h18;
   localparam logic [7:0] REG_START          = 8'h1c;
   localparam logic [7:0] REG_DEBUG_WORD     = 8'h20;
   localparam logic [7:0] REG_CYC_NO_TASK    = 8'h80;
   localparam logic [7:0] REG_CYC_PROCESSED  = 8'h84;
   localparam logic [7:0] REG_CYC_STALL_FIFO = 8'h88;
   localparam logic [7:0] REG_CYC_STALL_MEM  = 8'h8c;
   localparam logic [7:0] REG_CYC_UNASSIGNED = 8'ha0;

   typedef logic [THREAD_ID_WIDTH-1:0]   thread_id_t;
   typedef thread_id_t                   id_t;       // read tag is the thread.
   typedef logic [LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;

   typedef enum logic [3:0] {
      TASK_NORMAL           = 4'h0,
      TASK_UNDO_LOG_RESTORE = 4'h1,
      TASK_SPILL            = 4'h2
   } task_type_e;

   typedef struct packed {
      task_type_e  ttype;
      logic [31:0] ts;
      logic [31:0] object;
      logic        no_read;
   } task_t;

   typedef struct packed {
      task_t               task_desc;
      cq_slot_t            cq_slot;
      thread_id_t          thread;
      logic [RW_WIDTH-1:0] object;
   } rw_write_t;

   typedef struct packed {
      logic        wvalid;
      logic [7:0]  waddr;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef struct packed {
      logic       arvalid;
      logic [7:0] araddr;
   } reg_rd_req_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } reg_rd_resp_t;

   // each counted cycle falls into exactly one of these classes.
   localparam int N_CYC_CLASSES = 5;

   typedef enum logic [2:0] {
      CLS_NO_TASK,
      CLS_PROCESSED,
      CLS_STALL_FIFO,
      CLS_STALL_MEM,
      CLS_UNASSIGNED
   } cyc_class_e;

endpackage
